// ==== Makefile ====
# Verilator build and run of the event unit testbench

VERILATOR ?= verilator
TOP       ?= tb_eu_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

PASS_LINE := RESULT: PASS

.DEFAULT_GOAL := help
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_LINE)"

clean:
	rm -rf $(BUILD_DIR)

// ==== eu_bus_port.sv ====
`include "eu_settings.svh"

module eu_bus_port (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // core link
  input  logic                     req_i,
  input  logic                     we_n_i,
  input  eu_pkg::eu_reg_e          addr_i,
  input  logic [`EU_DATA_W-1:0]    wdata_i,
  input  logic                     grant_en_i,

  // register views for readback
  input  logic [`EU_NB_EVENTS-1:0] evt_mask_i,
  input  logic [`EU_NB_EVENTS-1:0] irq_mask_i,
  input  logic [`EU_NB_EVENTS-1:0] evt_buf_i,
  input  logic [`EU_NB_EVENTS-1:0] evt_buf_masked_i,
  input  logic [`EU_NB_EVENTS-1:0] irq_buf_masked_i,
  input  eu_pkg::eu_clk_state_e    clk_state_i,

  output logic                     gnt_o,
  output logic                     rvalid_o,
  output logic [`EU_DATA_W-1:0]    rdata_o,
  output logic                     sleep_req_o,
  output logic                     clear_req_o,
  output logic                     wr_en_o,
  output eu_pkg::eu_reg_e          wr_addr_o,
  output logic [`EU_DATA_W-1:0]    wdata_o
);

  logic            gnt;
  logic            rvalid_q;
  logic            rd_q;
  eu_pkg::eu_reg_e addr_q;
  logic            is_wait;

  assign is_wait = (addr_i == eu_pkg::EVT_WAIT) || (addr_i == eu_pkg::EVT_WAIT_CLR);

  assign sleep_req_o = req_i & we_n_i & is_wait;
  assign clear_req_o = sleep_req_o & (addr_i == eu_pkg::EVT_WAIT_CLR);

  assign gnt     = req_i & grant_en_i;
  assign gnt_o   = gnt;
  assign wr_en_o = gnt & ~we_n_i;

  // write path sees data only on a granted write
  assign wr_addr_o = addr_i;
  assign wdata_o   = wr_en_o ? wdata_i : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      rd_q     <= 1'b0;
    end else begin
      rvalid_q <= gnt;
      rd_q     <= gnt & we_n_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      addr_q <= addr_i;
    end
  end

  // response data, writes answer with zero
  always_comb begin
    rdata_o = '0;
    if (rd_q) begin
      case (addr_q)
        eu_pkg::EVT_MASK:       rdata_o = evt_mask_i;
        eu_pkg::IRQ_MASK:       rdata_o = irq_mask_i;
        eu_pkg::CLK_STATUS:     rdata_o = {{(`EU_DATA_W-1){1'b0}}, clk_state_i != eu_pkg::SLEEP};
        eu_pkg::EVT_BUF:        rdata_o = evt_buf_i;
        eu_pkg::EVT_BUF_MASKED: rdata_o = evt_buf_masked_i;
        eu_pkg::IRQ_BUF_MASKED: rdata_o = irq_buf_masked_i;
        eu_pkg::EVT_WAIT:       rdata_o = evt_buf_masked_i;
        eu_pkg::EVT_WAIT_CLR:   rdata_o = evt_buf_masked_i;
        default:                rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = rvalid_q;

endmodule

// ==== eu_core_top.sv ====
`include "eu_settings.svh"

module eu_core_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // core link
  input  logic                     req_i,
  input  logic                     we_n_i,
  input  eu_pkg::eu_reg_e          addr_i,
  input  logic [`EU_DATA_W-1:0]    wdata_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output logic [`EU_DATA_W-1:0]    rdata_o,

  input  logic [`EU_NB_EVENTS-1:0] event_lines_i,

  // interrupt handshake
  output logic                     irq_req_o,
  output logic [`EU_IRQ_ID_W-1:0]  irq_id_o,
  input  logic                     irq_ack_i,
  input  logic [`EU_IRQ_ID_W-1:0]  irq_ack_id_i,

  input  logic                     core_busy_i,
  output logic                     core_clock_en_o
);

  logic [`EU_NB_EVENTS-1:0] evt_mask;
  logic [`EU_NB_EVENTS-1:0] irq_mask;
  logic [`EU_NB_EVENTS-1:0] evt_buf;
  logic [`EU_NB_EVENTS-1:0] evt_buf_masked;
  logic [`EU_NB_EVENTS-1:0] irq_buf_masked;
  logic [`EU_NB_EVENTS-1:0] irq_clear_mask;
  logic                     irq_pending;
  logic                     wait_clear;
  logic                     grant_en;
  logic                     sleep_req;
  logic                     clear_req;
  logic                     wr_en;
  eu_pkg::eu_reg_e          wr_addr;
  logic [`EU_DATA_W-1:0]    wr_data;
  eu_pkg::eu_clk_state_e    clk_state;

  eu_reg_file u_reg_file (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .wr_en_i          (wr_en),
    .wr_addr_i        (wr_addr),
    .wdata_i          (wr_data),
    .event_lines_i    (event_lines_i),
    .irq_clear_mask_i (irq_clear_mask),
    .wait_clear_i     (wait_clear),
    .evt_mask_o       (evt_mask),
    .irq_mask_o       (irq_mask),
    .evt_buf_o        (evt_buf),
    .evt_buf_masked_o (evt_buf_masked),
    .irq_buf_masked_o (irq_buf_masked)
  );

  eu_irq_ctrl u_irq_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .irq_buf_masked_i (irq_buf_masked),
    .irq_ack_i        (irq_ack_i),
    .irq_ack_id_i     (irq_ack_id_i),
    .irq_req_o        (irq_req_o),
    .irq_id_o         (irq_id_o),
    .irq_pending_o    (irq_pending),
    .irq_clear_mask_o (irq_clear_mask)
  );

  eu_sleep_fsm u_sleep_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .sleep_req_i     (sleep_req),
    .clear_req_i     (clear_req),
    .evt_pending_i   (|evt_buf_masked),
    .irq_pending_i   (irq_pending),
    .core_busy_i     (core_busy_i),
    .grant_en_o      (grant_en),
    .wait_clear_o    (wait_clear),
    .core_clock_en_o (core_clock_en_o),
    .clk_state_o     (clk_state)
  );

  eu_bus_port u_bus_port (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .we_n_i           (we_n_i),
    .addr_i           (addr_i),
    .wdata_i          (wdata_i),
    .grant_en_i       (grant_en),
    .evt_mask_i       (evt_mask),
    .irq_mask_i       (irq_mask),
    .evt_buf_i        (evt_buf),
    .evt_buf_masked_i (evt_buf_masked),
    .irq_buf_masked_i (irq_buf_masked),
    .clk_state_i      (clk_state),
    .gnt_o            (gnt_o),
    .rvalid_o         (rvalid_o),
    .rdata_o          (rdata_o),
    .sleep_req_o      (sleep_req),
    .clear_req_o      (clear_req),
    .wr_en_o          (wr_en),
    .wr_addr_o        (wr_addr),
    .wdata_o          (wr_data)
  );

endmodule

// ==== eu_irq_ctrl.sv ====
`include "eu_settings.svh"

module eu_irq_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`EU_NB_EVENTS-1:0] irq_buf_masked_i,

  // acknowledge from the core
  input  logic                     irq_ack_i,
  input  logic [`EU_IRQ_ID_W-1:0]  irq_ack_id_i,

  output logic                     irq_req_o,
  output logic [`EU_IRQ_ID_W-1:0]  irq_id_o,
  output logic                     irq_pending_o,
  output logic [`EU_NB_EVENTS-1:0] irq_clear_mask_o
);

  logic [`EU_IRQ_ID_W-1:0] irq_sel_id;
  logic                    irq_req_q;

  // lowest index wins, scan downwards so the last hit is kept
  always_comb begin
    irq_sel_id = '0;
    for (int i = `EU_NB_EVENTS - 1; i >= 0; i--) begin
      if (irq_buf_masked_i[i]) begin
        irq_sel_id = `EU_IRQ_ID_W'(i);
      end
    end
  end

  // one-cold mask, all ones when there is no acknowledge
  always_comb begin
    irq_clear_mask_o = '1;
    if (irq_ack_i) begin
      irq_clear_mask_o[irq_ack_id_i] = 1'b0;
    end
  end

  assign irq_pending_o = |irq_buf_masked_i;

  // request lags the buffer by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_req_q <= 1'b0;
    end else begin
      irq_req_q <= irq_pending_o;
    end
  end

  assign irq_req_o = irq_req_q;
  assign irq_id_o  = irq_sel_id;

endmodule

// ==== eu_pkg.sv ====
`include "eu_settings.svh"

package eu_pkg;

  // core clock states
  typedef enum logic [1:0] {
    ACTIVE          = 2'd0,
    SLEEP           = 2'd1,
    IRQ_WHILE_SLEEP = 2'd2
  } eu_clk_state_e;

  // word offsets of the core link registers
  typedef enum logic [`EU_ADDR_W-1:0] {
    EVT_MASK       = 4'd0,
    EVT_MASK_CLR   = 4'd1,
    EVT_MASK_SET   = 4'd2,
    IRQ_MASK       = 4'd3,
    IRQ_MASK_CLR   = 4'd4,
    IRQ_MASK_SET   = 4'd5,
    CLK_STATUS     = 4'd6,
    EVT_BUF        = 4'd7,
    EVT_BUF_MASKED = 4'd8,
    IRQ_BUF_MASKED = 4'd9,
    EVT_BUF_CLR    = 4'd10,
    // reads of these two stall until a masked event is present
    EVT_WAIT       = 4'd14,
    EVT_WAIT_CLR   = 4'd15
  } eu_reg_e;

endpackage

// ==== eu_reg_file.sv ====
`include "eu_settings.svh"

module eu_reg_file (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // write port from the bus decode
  input  logic                     wr_en_i,
  input  eu_pkg::eu_reg_e          wr_addr_i,
  input  logic [`EU_DATA_W-1:0]    wdata_i,

  // event pulses and buffer clear sources
  input  logic [`EU_NB_EVENTS-1:0] event_lines_i,
  input  logic [`EU_NB_EVENTS-1:0] irq_clear_mask_i,
  input  logic                     wait_clear_i,

  output logic [`EU_NB_EVENTS-1:0] evt_mask_o,
  output logic [`EU_NB_EVENTS-1:0] irq_mask_o,
  output logic [`EU_NB_EVENTS-1:0] evt_buf_o,
  output logic [`EU_NB_EVENTS-1:0] evt_buf_masked_o,
  output logic [`EU_NB_EVENTS-1:0] irq_buf_masked_o
);

  logic [`EU_NB_EVENTS-1:0] evt_mask_q;
  logic [`EU_NB_EVENTS-1:0] evt_mask_d;
  logic [`EU_NB_EVENTS-1:0] irq_mask_q;
  logic [`EU_NB_EVENTS-1:0] irq_mask_d;
  logic [`EU_NB_EVENTS-1:0] evt_buf_q;
  logic [`EU_NB_EVENTS-1:0] evt_buf_d;
  logic [`EU_NB_EVENTS-1:0] wdata_evt;
  logic                     buf_clr_we;

  assign wdata_evt = wdata_i[`EU_NB_EVENTS-1:0];

  // write decode, plain / clear / set forms of both masks
  always_comb begin
    evt_mask_d = evt_mask_q;
    irq_mask_d = irq_mask_q;
    buf_clr_we = 1'b0;
    if (wr_en_i) begin
      case (wr_addr_i)
        eu_pkg::EVT_MASK:     evt_mask_d = wdata_evt;
        eu_pkg::EVT_MASK_CLR: evt_mask_d = evt_mask_q & ~wdata_evt;
        eu_pkg::EVT_MASK_SET: evt_mask_d = evt_mask_q | wdata_evt;
        eu_pkg::IRQ_MASK:     irq_mask_d = wdata_evt;
        eu_pkg::IRQ_MASK_CLR: irq_mask_d = irq_mask_q & ~wdata_evt;
        eu_pkg::IRQ_MASK_SET: irq_mask_d = irq_mask_q | wdata_evt;
        eu_pkg::EVT_BUF_CLR:  buf_clr_we = 1'b1;
        default: ;
      endcase
    end
  end

  // event buffer update
  always_comb begin
    evt_buf_d = evt_buf_q | event_lines_i;
    if (wait_clear_i) begin
      // wait-clear drops the masked bits it just reported
      evt_buf_d = (evt_buf_q & ~evt_mask_q) | event_lines_i;
    end else if (buf_clr_we) begin
      evt_buf_d = (evt_buf_q & ~wdata_evt) | event_lines_i;
    end
    // acknowledged interrupt bit goes away in every case
    evt_buf_d = evt_buf_d & irq_clear_mask_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_mask_q <= '0;
      irq_mask_q <= '0;
      evt_buf_q  <= '0;
    end else begin
      evt_mask_q <= evt_mask_d;
      irq_mask_q <= irq_mask_d;
      evt_buf_q  <= evt_buf_d;
    end
  end

  assign evt_mask_o       = evt_mask_q;
  assign irq_mask_o       = irq_mask_q;
  assign evt_buf_o        = evt_buf_q;
  assign evt_buf_masked_o = evt_buf_q & evt_mask_q;
  assign irq_buf_masked_o = evt_buf_q & irq_mask_q;

endmodule

// ==== eu_settings.svh ====
`ifndef EU_SETTINGS_SVH
`define EU_SETTINGS_SVH

// number of event lines, one buffer bit each
`define EU_NB_EVENTS 32

// data width of the core link
`define EU_DATA_W 32

// register word offset width
`define EU_ADDR_W 4

// interrupt id width, log2 of the event count
`define EU_IRQ_ID_W 5

`endif

// ==== eu_sleep_fsm.sv ====
module eu_sleep_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // wait read decode from the bus port
  input  logic                  sleep_req_i,
  input  logic                  clear_req_i,

  input  logic                  evt_pending_i,
  input  logic                  irq_pending_i,
  input  logic                  core_busy_i,

  output logic                  grant_en_o,
  output logic                  wait_clear_o,
  output logic                  core_clock_en_o,
  output eu_pkg::eu_clk_state_e clk_state_o
);

  eu_pkg::eu_clk_state_e state_q;
  eu_pkg::eu_clk_state_e state_d;
  logic                  grant_ok;
  logic                  wait_clear_d;
  logic                  wait_clear_q;

  always_comb begin
    state_d         = state_q;
    core_clock_en_o = 1'b1;
    grant_ok        = 1'b1;
    wait_clear_d    = 1'b0;

    case (state_q)
      eu_pkg::ACTIVE: begin
        if (sleep_req_i) begin
          if (irq_pending_i) begin
            // let the core take the interrupt first, wait is replayed later
            grant_ok = 1'b0;
            state_d  = eu_pkg::IRQ_WHILE_SLEEP;
          end else if (evt_pending_i) begin
            // event already there, answer right away
            wait_clear_d = clear_req_i;
          end else begin
            grant_ok = 1'b0;
            if (!core_busy_i) begin
              state_d = eu_pkg::SLEEP;
            end
          end
        end
      end

      eu_pkg::SLEEP: begin
        core_clock_en_o = 1'b0;
        grant_ok        = 1'b0;
        if (irq_pending_i) begin
          core_clock_en_o = 1'b1;
          state_d         = eu_pkg::IRQ_WHILE_SLEEP;
        end else if (evt_pending_i) begin
          // wake up and release the stalled read in the same cycle
          core_clock_en_o = 1'b1;
          grant_ok        = 1'b1;
          wait_clear_d    = clear_req_i;
          state_d         = eu_pkg::ACTIVE;
        end
      end

      eu_pkg::IRQ_WHILE_SLEEP: begin
        if (sleep_req_i) begin
          if (irq_pending_i) begin
            grant_ok = 1'b0;
          end else if (evt_pending_i) begin
            wait_clear_d = clear_req_i;
            state_d      = eu_pkg::ACTIVE;
          end else begin
            grant_ok = 1'b0;
            if (!core_busy_i) begin
              state_d = eu_pkg::SLEEP;
            end
          end
        end
      end

      default: state_d = eu_pkg::ACTIVE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= eu_pkg::ACTIVE;
      wait_clear_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      // no second clear while the first one is still being applied
      wait_clear_q <= sleep_req_i & wait_clear_d & grant_ok & ~wait_clear_q;
    end
  end

  // the cycle that applies a wait-clear takes no new access
  assign grant_en_o   = grant_ok & ~wait_clear_q;
  assign wait_clear_o = wait_clear_q;
  assign clk_state_o  = state_q;

endmodule

// ==== eu_tests.txt ====
# op W addr data | R addr expect | E lines | A id | I req id | C state | T addr lines expect
# all fields hex, addr is the register word offset, state 0 ACTIVE 1 SLEEP
C 0
W 0 0000F0F0
R 0 0000F0F0
W 2 00000F0F
R 0 0000FFFF
W 1 000000F0
R 0 0000FF0F
W 3 00000011
W 5 00000104
W 4 00000001
R 3 00000114
E 00030001
R 7 00030001
R 8 00000001
W A 00010000
R 7 00020001
E 00000110
R 9 00000110
I 1 4
A 4
I 1 8
A 8
I 0 0
E 00000003
R F 00000003
R 7 00020000
T E 00000008 00000008
C 0
R 7 00020008

// ==== flist.f ====
+incdir+.
eu_pkg.sv
eu_reg_file.sv
eu_irq_ctrl.sv
eu_sleep_fsm.sv
eu_bus_port.sv
eu_core_top.sv
tb_eu_asserts.sv
tb_eu_core.sv

// ==== tb_eu_asserts.sv ====
`include "eu_settings.svh"

module tb_eu_asserts (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     req_i,
  input logic                     we_n_i,
  input eu_pkg::eu_reg_e          addr_i,
  input logic                     gnt_o,
  input logic                     rvalid_o,
  input logic [`EU_DATA_W-1:0]    rdata_o,
  input logic                     core_clock_en_o,
  input logic                     irq_req_o,
  input logic [`EU_NB_EVENTS-1:0] event_lines_i,
  input eu_pkg::eu_clk_state_e    clk_state_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic seen_event;
  logic wait_rd;

  // any event pulse since reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_event <= 1'b0;
    end else if (|event_lines_i) begin
      seen_event <= 1'b1;
    end
  end

  // a wait read is held on the link
  assign wait_rd = req_i && we_n_i &&
                   (addr_i == eu_pkg::EVT_WAIT || addr_i == eu_pkg::EVT_WAIT_CLR);

  // writes are answered with zero data
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_o |=> rvalid_o && ($past(we_n_i) || rdata_o == '0))
    else $error("rvalid_o missing or write data not zero one cycle after gnt_o");

  // the cycle after a granted wait-clear read takes no access
  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_o |-> req_i && !$past(gnt_o && we_n_i && addr_i == eu_pkg::EVT_WAIT_CLR))
    else $error("gnt_o high without req_i or right after a wait-clear grant");

  gated_only_in_sleep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !core_clock_en_o |-> clk_state_i == eu_pkg::SLEEP && wait_rd && !gnt_o)
    else $error("core clock gated outside SLEEP or without a stalled wait read");

  no_irq_before_event: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seen_event |-> !irq_req_o) else $error("irq_req_o raised before any event");

endmodule

bind eu_core_top tb_eu_asserts u_asserts (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .req_i           (req_i),
  .we_n_i          (we_n_i),
  .addr_i          (addr_i),
  .gnt_o           (gnt_o),
  .rvalid_o        (rvalid_o),
  .rdata_o         (rdata_o),
  .core_clock_en_o (core_clock_en_o),
  .irq_req_o       (irq_req_o),
  .event_lines_i   (event_lines_i),
  .clk_state_i     (clk_state)
);

// ==== tb_eu_core.sv ====
`include "eu_settings.svh"

module tb_eu_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 8;
  localparam int CYCLES_PER_LINE = 50;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     req_i;
  logic                     we_n_i;
  eu_pkg::eu_reg_e          addr_i;
  logic [`EU_DATA_W-1:0]    wdata_i;
  logic                     gnt_o;
  logic                     rvalid_o;
  logic [`EU_DATA_W-1:0]    rdata_o;
  logic [`EU_NB_EVENTS-1:0] event_lines_i;
  logic                     irq_req_o;
  logic [`EU_IRQ_ID_W-1:0]  irq_id_o;
  logic                     irq_ack_i;
  logic [`EU_IRQ_ID_W-1:0]  irq_ack_id_i;
  logic                     core_busy_i;
  logic                     core_clock_en_o;

  logic [7:0]  op_q[$];
  logic [31:0] fa_q[$];
  logic [31:0] fb_q[$];
  logic [31:0] fc_q[$];
  int          watch_cycles = 0;
  int          n_checks = 0;
  int          err_rdata = 0;
  int          err_irq = 0;
  int          err_state = 0;
  int          err_other = 0;

  eu_core_top u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .we_n_i          (we_n_i),
    .addr_i          (addr_i),
    .wdata_i         (wdata_i),
    .gnt_o           (gnt_o),
    .rvalid_o        (rvalid_o),
    .rdata_o         (rdata_o),
    .event_lines_i   (event_lines_i),
    .irq_req_o       (irq_req_o),
    .irq_id_o        (irq_id_o),
    .irq_ack_i       (irq_ack_i),
    .irq_ack_id_i    (irq_ack_id_i),
    .core_busy_i     (core_busy_i),
    .core_clock_en_o (core_clock_en_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // clock running means anything but SLEEP, same for the CLK_STATUS bit
  function automatic eu_pkg::eu_clk_state_e state_from_run_bit(input logic run);
    return run ? eu_pkg::ACTIVE : eu_pkg::SLEEP;
  endfunction

  task automatic check_rdata(input string name, input logic [`EU_DATA_W-1:0] exp,
                             input logic [`EU_DATA_W-1:0] act);
    n_checks++;
    if (act !== exp) begin
      err_rdata++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_irq_id(input string name, input logic [`EU_IRQ_ID_W-1:0] exp,
                              input logic [`EU_IRQ_ID_W-1:0] act);
    n_checks++;
    if (act !== exp) begin
      err_irq++;
      $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_irq_req(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      err_irq++;
      $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_state(input string name, input eu_pkg::eu_clk_state_e exp,
                             input eu_pkg::eu_clk_state_e act);
    n_checks++;
    if (act !== exp) begin
      err_state++;
      $display("[FAIL] %0t %s expected %s got %s", $time, name, exp.name(), act.name());
    end
  endtask

  task automatic load_tests(output int count);
    int    fd;
    int    n;
    string line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("eu_tests.txt", "r");
    if (fd == 0) begin
      err_other++;
      $display("could not open eu_tests.txt for reading");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          a = '0;
          b = '0;
          c = '0;
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
          op_q.push_back(line[0]);
          fa_q.push_back(a);
          fb_q.push_back(b);
          fc_q.push_back(c);
        end
      end
      $fclose(fd);
    end
    count = op_q.size();
  endtask

  // starts and ends on a falling edge, holds the request until rvalid shows up
  task automatic bus_access(input logic we_n, input logic [31:0] addr,
                            input logic [31:0] data, output logic [`EU_DATA_W-1:0] rdata);
    req_i   = 1'b1;
    we_n_i  = we_n;
    addr_i  = eu_pkg::eu_reg_e'(addr[`EU_ADDR_W-1:0]);
    wdata_i = data;
    do @(negedge clk_i); while (!rvalid_o);
    rdata   = rdata_o;
    req_i   = 1'b0;
    we_n_i  = 1'b1;
    wdata_i = '0;
  endtask

  task automatic pulse_events(input logic [31:0] lines);
    event_lines_i = lines[`EU_NB_EVENTS-1:0];
    @(negedge clk_i);
    event_lines_i = '0;
  endtask

  task automatic pulse_ack(input logic [31:0] id);
    irq_ack_i    = 1'b1;
    irq_ack_id_i = id[`EU_IRQ_ID_W-1:0];
    @(negedge clk_i);
    irq_ack_i    = 1'b0;
    irq_ack_id_i = '0;
  endtask

  // wait read with nothing pending, core must sleep until the event comes
  task automatic run_wait(input logic [31:0] addr, input logic [31:0] lines,
                          input logic [31:0] exp);
    req_i   = 1'b1;
    we_n_i  = 1'b1;
    addr_i  = eu_pkg::eu_reg_e'(addr[`EU_ADDR_W-1:0]);
    wdata_i = '0;
    do @(negedge clk_i); while (core_clock_en_o && !rvalid_o);
    if (rvalid_o) begin
      err_other++;
      $display("wait read at offset %h returned before the core clock was gated", addr);
      req_i = 1'b0;
    end else begin
      @(negedge clk_i);
      check_state("core_clock_en_o", eu_pkg::SLEEP, state_from_run_bit(core_clock_en_o));
      pulse_events(lines);
      while (!rvalid_o) @(negedge clk_i);
      req_i = 1'b0;
      check_rdata("rdata_o", exp, rdata_o);
      check_state("core_clock_en_o", eu_pkg::ACTIVE, state_from_run_bit(core_clock_en_o));
    end
  endtask

  task automatic print_counts;
    $display("checks %0d, errors: rdata %0d, irq %0d, state %0d, other %0d",
             n_checks, err_rdata, err_irq, err_state, err_other);
  endtask

  initial begin
    int          n_ops;
    logic [31:0] rd;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    we_n_i        = 1'b1;
    addr_i        = eu_pkg::EVT_MASK;
    wdata_i       = '0;
    event_lines_i = '0;
    irq_ack_i     = 1'b0;
    irq_ack_id_i  = '0;
    core_busy_i   = 1'b0;
    void'($urandom(32'ha500_a1fe));
    load_tests(n_ops);
    watch_cycles = RESET_CYCLES + CYCLES_PER_LINE * (n_ops + 1);
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    check_irq_req("irq_req_o", 1'b0, irq_req_o);
    check_state("core_clock_en_o", eu_pkg::ACTIVE, state_from_run_bit(core_clock_en_o));
    for (int i = 0; i < n_ops; i++) begin
      // idle gap between operations
      repeat ($urandom % 3) @(negedge clk_i);
      case (op_q[i])
        "W": begin
          bus_access(1'b0, fa_q[i], fb_q[i], rd);
          check_rdata("rdata_o", '0, rd);
        end
        "R": begin
          bus_access(1'b1, fa_q[i], '0, rd);
          check_rdata("rdata_o", fb_q[i], rd);
        end
        "E": pulse_events(fa_q[i]);
        "A": pulse_ack(fa_q[i]);
        "I": begin
          // request is registered, give it one more cycle
          @(negedge clk_i);
          check_irq_req("irq_req_o", fa_q[i][0], irq_req_o);
          check_irq_id("irq_id_o", fb_q[i][`EU_IRQ_ID_W-1:0], irq_id_o);
        end
        "C": begin
          bus_access(1'b1, 32'(eu_pkg::CLK_STATUS), '0, rd);
          check_state("rdata_o", eu_pkg::eu_clk_state_e'(fa_q[i][1:0]),
                      state_from_run_bit(rd[0]));
        end
        "T": run_wait(fa_q[i], fb_q[i], fc_q[i]);
        default: begin
          err_other++;
          $display("unknown opcode %c on test line %0d", op_q[i], i);
        end
      endcase
    end
    repeat (2) @(negedge clk_i);
    print_counts();
    if (n_ops > 0 && err_rdata + err_irq + err_state + err_other == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge clk_i);
    $display("watchdog: tests did not finish within %0d cycles", watch_cycles);
    print_counts();
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
